//--- Makefile
# Verilator build and run of the RV32I core testbench

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tb_rv_core
RTL_TOP   ?= rv_core_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+src
src/rv_pkg.sv
src/dec_ex_if.sv
src/rv_regfile.sv
src/rv_decoder.sv
src/rv_execute.sv
src/rv_core_ctrl.sv
src/rv_core_top.sv
verification/tb_wb_mem.sv
verification/tb_rv_core.sv

//--- src/dec_ex_if.sv
`default_nettype none

interface dec_ex_if import rv_pkg::*; ();

	// alu and operands
	alu_op_e    alu_op;
	rv_word_t   op_a;
	rv_word_t   op_b;
	rv_word_t   imm;
	rv_word_t   pc;
	// destination
	logic [4:0] rd;
	logic       rd_wen;
	// control flow
	branch_e    branch;
	// memory access
	logic       is_load;
	logic       is_store;
	ls_size_e   size;
	logic       is_unsigned;
	rv_word_t   store_data;

	modport dec (
		output alu_op, op_a, op_b, imm, pc, rd, rd_wen, branch,
		output is_load, is_store, size, is_unsigned, store_data
	);

	modport exe (
		input alu_op, op_a, op_b, imm, pc, branch
	);

	modport ctrl (
		input rd, rd_wen, is_load, is_store, size, is_unsigned, store_data
	);

endinterface

`default_nettype wire

//--- src/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// base opcodes, instruction bits [6:0]
`define RV_OP_LUI     7'b0110111
`define RV_OP_AUIPC   7'b0010111
`define RV_OP_JAL     7'b1101111
`define RV_OP_JALR    7'b1100111
`define RV_OP_BRANCH  7'b1100011
`define RV_OP_LOAD    7'b0000011
`define RV_OP_STORE   7'b0100011
`define RV_OP_OPIMM   7'b0010011
`define RV_OP_OP      7'b0110011
`define RV_OP_SYSTEM  7'b1110011

// funct3 for alu ops, shared by op and op-imm
`define RV_F3_ADD     3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// funct3 for branches
`define RV_F3_BEQ     3'b000
`define RV_F3_BNE     3'b001
`define RV_F3_BLT     3'b100
`define RV_F3_BGE     3'b101
`define RV_F3_BLTU    3'b110
`define RV_F3_BGEU    3'b111

// funct3 for loads and stores, bit 2 is the unsigned flag
`define RV_F3_LB      3'b000
`define RV_F3_LH      3'b001
`define RV_F3_LW      3'b010
`define RV_F3_LBU     3'b100
`define RV_F3_LHU     3'b101
`define RV_F3_SB      3'b000
`define RV_F3_SH      3'b001
`define RV_F3_SW      3'b010
`define RV_F3_JALR    3'b000

// funct7 variants, alt selects sub and sra
`define RV_F7_BASE    7'b0000000
`define RV_F7_ALT     7'b0100000

// the one system encoding that is accepted
`define RV_INST_EBREAK 32'h0010_0073

`define RV_RESET_VEC  32'h0000_0000
`define RV_NREGS      32

`endif

//--- src/rv_core_ctrl.sv
`default_nettype none

`include "rv_consts.svh"

module rv_core_ctrl import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	output rv_inst_u   inst_o,
	input  logic       illegal_i,
	input  logic       ebreak_i,
	dec_ex_if.ctrl     de,
	input  rv_word_t   alu_result_i,
	input  logic       taken_i,
	input  rv_word_t   target_i,
	output logic       rd_wen_o,
	output logic [4:0] rd_addr_o,
	output rv_word_t   rd_data_o,
	output rv_word_t   pc_o,
	output rv_word_t   adr_o,
	output rv_word_t   dat_o,
	input  rv_word_t   dat_i,
	output logic [3:0] sel_o,
	output logic       we_o,
	output logic       cyc_o,
	output logic       stb_o,
	input  logic       ack_i,
	output logic       halt_o,
	output logic       invalid_o
);

	ctrl_state_e state;
	rv_word_t    pc_next;
	rv_word_t    lane_data;
	logic [3:0]  lane_sel;
	logic [7:0]  load_byte;
	logic [15:0] load_half;
	rv_word_t    load_ext;
	logic        stop;

	assign stop    = illegal_i || ebreak_i;
	assign pc_next = taken_i ? target_i : pc_o + 32'd4;

	// store lanes from the size and low address bits
	always_comb begin
		case (de.size)
			LS_BYTE: begin
				lane_data = {4{de.store_data[7:0]}};
				lane_sel  = 4'b0001 << alu_result_i[1:0];
			end
			LS_HALF: begin
				lane_data = {2{de.store_data[15:0]}};
				lane_sel  = alu_result_i[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				lane_data = de.store_data;
				lane_sel  = 4'b1111;
			end
		endcase
	end

	// load lane picked by the latched address
	assign load_byte = dat_i[8*adr_o[1:0] +: 8];
	assign load_half = adr_o[1] ? dat_i[31:16] : dat_i[15:0];

	always_comb begin
		case (de.size)
			LS_BYTE: load_ext = {{24{!de.is_unsigned && load_byte[7]}}, load_byte};
			LS_HALF: load_ext = {{16{!de.is_unsigned && load_half[15]}}, load_half};
			default: load_ext = dat_i;
		endcase
	end

	// alu results retire in exec, loads on the data ack
	assign rd_wen_o  = (state == ST_EXEC && !stop && de.rd_wen && !de.is_load) ||
		(state == ST_MEM && ack_i && de.is_load && de.rd_wen);
	assign rd_addr_o = de.rd;
	assign rd_data_o = (state == ST_MEM) ? load_ext : alu_result_i;

	always_ff @(posedge clk) begin
		if (!rst) begin
			state     <= ST_FETCH;
			pc_o      <= `RV_RESET_VEC;
			cyc_o     <= 1'b0;
			stb_o     <= 1'b0;
			we_o      <= 1'b0;
			halt_o    <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			case (state)
				ST_FETCH: begin
					// idle cycle after reset or a data access
					if (!cyc_o) begin
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= 1'b0;
						adr_o <= pc_o;
						sel_o <= 4'b1111;
					end else if (ack_i) begin
						cyc_o  <= 1'b0;
						stb_o  <= 1'b0;
						inst_o <= dat_i;
						state  <= ST_EXEC;
					end
				end
				ST_EXEC: begin
					if (stop) begin
						halt_o    <= ebreak_i;
						invalid_o <= illegal_i;
						state     <= ST_STOP;
					end else if (de.is_load || de.is_store) begin
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= de.is_store;
						adr_o <= alu_result_i;
						dat_o <= lane_data;
						sel_o <= lane_sel;
						state <= ST_MEM;
					end else begin
						// next fetch starts right away
						pc_o  <= pc_next;
						cyc_o <= 1'b1;
						stb_o <= 1'b1;
						we_o  <= 1'b0;
						adr_o <= pc_next;
						sel_o <= 4'b1111;
						state <= ST_FETCH;
					end
				end
				ST_MEM: begin
					if (ack_i) begin
						cyc_o <= 1'b0;
						stb_o <= 1'b0;
						we_o  <= 1'b0;
						pc_o  <= pc_o + 32'd4;
						state <= ST_FETCH;
					end
				end
				// stop holds until reset
				default: state <= ST_STOP;
			endcase
		end
	end

	a_cyc_stb: assert property (@(posedge clk) disable iff (!rst)
		cyc_o == stb_o);

	// a waiting master keeps its address
	a_adr_hold: assert property (@(posedge clk) disable iff (!rst)
		cyc_o && !ack_i |=> $stable(adr_o));

endmodule

`default_nettype wire

//--- src/rv_core_top.sv
`default_nettype none

module rv_core_top import rv_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	output logic [31:0] wb_adr_o,
	output logic [31:0] wb_dat_o,
	input  logic [31:0] wb_dat_i,
	output logic [3:0]  wb_sel_o,
	output logic        wb_we_o,
	output logic        wb_cyc_o,
	output logic        wb_stb_o,
	input  logic        wb_ack_i,
	output logic [31:0] pc_o,
	output logic        halt_o,
	output logic        invalid_o
);

	// decoded instruction, valid in exec
	dec_ex_if de ();

	rv_inst_u   inst;
	logic       illegal;
	logic       ebreak;
	rv_word_t   alu_result;
	logic       taken;
	rv_word_t   target;
	// register file ports
	logic       rd_wen;
	logic [4:0] rd_addr;
	rv_word_t   rd_data;
	logic [4:0] rs1_addr;
	logic [4:0] rs2_addr;
	rv_word_t   rs1_data;
	rv_word_t   rs2_data;

	rv_core_ctrl u_ctrl (
		.clk          (clk),
		.rst          (rst),
		.inst_o       (inst),
		.illegal_i    (illegal),
		.ebreak_i     (ebreak),
		.de           (de.ctrl),
		.alu_result_i (alu_result),
		.taken_i      (taken),
		.target_i     (target),
		.rd_wen_o     (rd_wen),
		.rd_addr_o    (rd_addr),
		.rd_data_o    (rd_data),
		.pc_o         (pc_o),
		.adr_o        (wb_adr_o),
		.dat_o        (wb_dat_o),
		.dat_i        (wb_dat_i),
		.sel_o        (wb_sel_o),
		.we_o         (wb_we_o),
		.cyc_o        (wb_cyc_o),
		.stb_o        (wb_stb_o),
		.ack_i        (wb_ack_i),
		.halt_o       (halt_o),
		.invalid_o    (invalid_o)
	);

	rv_decoder u_decoder (
		.inst_i     (inst),
		.pc_i       (pc_o),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.de         (de.dec),
		.illegal_o  (illegal),
		.ebreak_o   (ebreak)
	);

	rv_regfile u_regfile (
		.clk      (clk),
		.rst      (rst),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.wen_i    (rd_wen),
		.waddr_i  (rd_addr),
		.wdata_i  (rd_data)
	);

	rv_execute u_execute (
		.de       (de.exe),
		.result_o (alu_result),
		.taken_o  (taken),
		.target_o (target)
	);

endmodule

`default_nettype wire

//--- src/rv_decoder.sv
`default_nettype none

`include "rv_consts.svh"

module rv_decoder import rv_pkg::*; (
	input  rv_inst_u   inst_i,
	input  rv_word_t   pc_i,
	output logic [4:0] rs1_addr_o,
	output logic [4:0] rs2_addr_o,
	input  rv_word_t   rs1_data_i,
	input  rv_word_t   rs2_data_i,
	dec_ex_if.dec      de,
	output logic       illegal_o,
	output logic       ebreak_o
);

	rv_word_t   imm_i;
	rv_word_t   imm_s;
	rv_word_t   imm_b;
	rv_word_t   imm_u;
	rv_word_t   imm_j;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       f7_base;
	logic       f7_alt;
	alu_op_e    arith_op;

	// fields sit at the same place in every format
	assign opcode     = inst_i.r.opcode;
	assign funct3     = inst_i.r.funct3;
	assign rs1_addr_o = inst_i.r.rs1;
	assign rs2_addr_o = inst_i.r.rs2;
	assign f7_base    = inst_i.r.funct7 == `RV_F7_BASE;
	assign f7_alt     = inst_i.r.funct7 == `RV_F7_ALT;

	// immediates, all sign extended from bit 31
	assign imm_i = {{20{inst_i.i.imm[11]}}, inst_i.i.imm};
	assign imm_s = {{20{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi, inst_i.s.imm_lo};
	assign imm_b = {{19{inst_i.s.imm_hi[6]}}, inst_i.s.imm_hi[6], inst_i.s.imm_lo[0],
		inst_i.s.imm_hi[5:0], inst_i.s.imm_lo[4:1], 1'b0};
	assign imm_u = {inst_i.u.imm, 12'b0};
	assign imm_j = {{11{inst_i.u.imm[19]}}, inst_i.u.imm[19], inst_i.u.imm[7:0],
		inst_i.u.imm[8], inst_i.u.imm[18:9], 1'b0};

	// alu op from funct3, sub only in reg-reg form
	always_comb begin
		case (funct3)
			`RV_F3_ADD:  arith_op = (opcode == `RV_OP_OP && f7_alt) ? ALU_SUB : ALU_ADD;
			`RV_F3_SLL:  arith_op = ALU_SLL;
			`RV_F3_SLT:  arith_op = ALU_SLT;
			`RV_F3_SLTU: arith_op = ALU_SLTU;
			`RV_F3_XOR:  arith_op = ALU_XOR;
			`RV_F3_SR:   arith_op = f7_alt ? ALU_SRA : ALU_SRL;
			`RV_F3_OR:   arith_op = ALU_OR;
			`RV_F3_AND:  arith_op = ALU_AND;
		endcase
	end

	// fields that never depend on the opcode
	assign de.pc          = pc_i;
	assign de.rd          = inst_i.r.rd;
	assign de.size        = ls_size_e'(funct3[1:0]);
	assign de.is_unsigned = funct3[2];
	assign de.store_data  = rs2_data_i;

	always_comb begin
		de.alu_op = ALU_ADD;
		de.op_a   = rs1_data_i;
		de.op_b   = rs2_data_i;
		de.imm    = imm_i;
		de.rd_wen = 1'b0;
		de.branch = BR_NONE;
		de.is_load  = 1'b0;
		de.is_store = 1'b0;
		illegal_o = 1'b0;
		ebreak_o  = 1'b0;
		case (opcode)
			`RV_OP_LUI: begin
				de.alu_op = ALU_PASS_B;
				de.op_b   = imm_u;
				de.imm    = imm_u;
				de.rd_wen = 1'b1;
			end
			`RV_OP_AUIPC: begin
				de.op_a   = pc_i;
				de.op_b   = imm_u;
				de.imm    = imm_u;
				de.rd_wen = 1'b1;
			end
			// jal targets pc, jalr targets rs1, both through op_a
			`RV_OP_JAL: begin
				de.op_a   = pc_i;
				de.imm    = imm_j;
				de.branch = BR_JUMP;
				de.rd_wen = 1'b1;
			end
			`RV_OP_JALR: begin
				de.branch = BR_JUMP;
				de.rd_wen = 1'b1;
				illegal_o = funct3 != `RV_F3_JALR;
			end
			// compare rs1 against rs2
			`RV_OP_BRANCH: begin
				de.imm = imm_b;
				case (funct3)
					`RV_F3_BEQ:  de.branch = BR_EQ;
					`RV_F3_BNE:  de.branch = BR_NE;
					`RV_F3_BLT:  de.branch = BR_LT;
					`RV_F3_BGE:  de.branch = BR_GE;
					`RV_F3_BLTU: de.branch = BR_LTU;
					`RV_F3_BGEU: de.branch = BR_GEU;
					default:     illegal_o = 1'b1;
				endcase
			end
			`RV_OP_LOAD: begin
				de.op_b    = imm_i;
				de.is_load = 1'b1;
				de.rd_wen  = 1'b1;
				illegal_o  = !(funct3 inside {`RV_F3_LB, `RV_F3_LH, `RV_F3_LW,
					`RV_F3_LBU, `RV_F3_LHU});
			end
			`RV_OP_STORE: begin
				de.op_b     = imm_s;
				de.imm      = imm_s;
				de.is_store = 1'b1;
				illegal_o   = !(funct3 inside {`RV_F3_SB, `RV_F3_SH, `RV_F3_SW});
			end
			// shift amounts allow only base, or alt for sra
			`RV_OP_OPIMM: begin
				de.alu_op = arith_op;
				de.op_b   = imm_i;
				de.rd_wen = 1'b1;
				illegal_o = (funct3 == `RV_F3_SLL && !f7_base) ||
					(funct3 == `RV_F3_SR && !(f7_base || f7_alt));
			end
			`RV_OP_OP: begin
				de.alu_op = arith_op;
				de.rd_wen = 1'b1;
				illegal_o = !(f7_base || (f7_alt &&
					(funct3 == `RV_F3_ADD || funct3 == `RV_F3_SR)));
			end
			`RV_OP_SYSTEM: begin
				ebreak_o  = inst_i == `RV_INST_EBREAK;
				illegal_o = inst_i != `RV_INST_EBREAK;
			end
			default: illegal_o = 1'b1;
		endcase
		// nothing architectural happens on a bad word
		if (illegal_o) begin
			de.rd_wen   = 1'b0;
			de.branch   = BR_NONE;
			de.is_load  = 1'b0;
			de.is_store = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- src/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
	dec_ex_if.exe    de,
	output rv_word_t result_o,
	output logic     taken_o,
	output rv_word_t target_o
);

	rv_word_t   alu_res;
	rv_word_t   jump_sum;
	logic [4:0] shamt;
	logic       eq;
	logic       lt;
	logic       ltu;

	assign shamt = de.op_b[4:0];

	always_comb begin
		case (de.alu_op)
			ALU_ADD:    alu_res = de.op_a + de.op_b;
			ALU_SUB:    alu_res = de.op_a - de.op_b;
			ALU_SLL:    alu_res = de.op_a << shamt;
			ALU_SLT:    alu_res = {31'b0, lt};
			ALU_SLTU:   alu_res = {31'b0, ltu};
			ALU_XOR:    alu_res = de.op_a ^ de.op_b;
			ALU_SRL:    alu_res = de.op_a >> shamt;
			ALU_SRA:    alu_res = rv_word_t'($signed(de.op_a) >>> shamt);
			ALU_OR:     alu_res = de.op_a | de.op_b;
			ALU_AND:    alu_res = de.op_a & de.op_b;
			ALU_PASS_B: alu_res = de.op_b;
			default:    alu_res = '0;
		endcase
	end

	// comparisons shared by slt and the branches
	assign eq  = de.op_a == de.op_b;
	assign lt  = $signed(de.op_a) < $signed(de.op_b);
	assign ltu = de.op_a < de.op_b;

	// jumps write the link, loads and stores get the address
	assign result_o = (de.branch == BR_JUMP) ? de.pc + 32'd4 : alu_res;

	always_comb begin
		case (de.branch)
			BR_EQ:   taken_o = eq;
			BR_NE:   taken_o = !eq;
			BR_LT:   taken_o = lt;
			BR_GE:   taken_o = !lt;
			BR_LTU:  taken_o = ltu;
			BR_GEU:  taken_o = !ltu;
			BR_JUMP: taken_o = 1'b1;
			default: taken_o = 1'b0;
		endcase
	end

	// op_a is pc for jal, rs1 for jalr
	assign jump_sum = de.op_a + de.imm;

	// bit 0 of a jal sum is already zero
	assign target_o = (de.branch == BR_JUMP) ? {jump_sum[31:1], 1'b0}
		: de.pc + de.imm;

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// data and address word
	typedef logic [31:0] rv_word_t;

	// register-register format
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_t;

	// immediate format, also loads and jalr
	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_t;

	// store format, branches reuse it with scrambled bits
	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} rv_s_t;

	// upper format, jal reuses it
	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_u_t;

	// one fetched word, seen through every format
	typedef union packed {
		rv_r_t r;
		rv_i_t i;
		rv_s_t s;
		rv_u_t u;
	} rv_inst_u;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
		ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JUMP
	} branch_e;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		LS_BYTE = 2'b00,
		LS_HALF = 2'b01,
		LS_WORD = 2'b10
	} ls_size_e;

	typedef enum logic [1:0] {
		ST_FETCH, ST_EXEC, ST_MEM, ST_STOP
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- src/rv_regfile.sv
`default_nettype none

`include "rv_consts.svh"

module rv_regfile import rv_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [4:0] raddr1_i,
	input  logic [4:0] raddr2_i,
	output rv_word_t   rdata1_o,
	output rv_word_t   rdata2_o,
	input  logic       wen_i,
	input  logic [4:0] waddr_i,
	input  rv_word_t   wdata_i
);

	rv_word_t regs [`RV_NREGS];

	// x0 only ever holds its reset value
	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int k = 0; k < `RV_NREGS; k++) begin
				regs[k] <= '0;
			end
		end else if (wen_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// async read, new value visible after the edge
	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	a_waddr_range: assert property (@(posedge clk) disable iff (!rst)
		wen_i |-> (32'(waddr_i) < `RV_NREGS));

endmodule

`default_nettype wire

//--- verification/tb_rv_core.sv
`default_nettype none

`include "rv_consts.svh"

module tb_rv_core import rv_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int LIMIT = 6 * 2000;
	localparam int DATA  = 32'h1000 >> 2;

	logic       clk;
	logic       rst;
	rv_word_t   wb_adr;
	rv_word_t   wb_dat_w;
	rv_word_t   wb_dat_r;
	logic [3:0] wb_sel;
	logic       wb_we;
	logic       wb_cyc;
	logic       wb_stb;
	logic       wb_ack;
	rv_word_t   pc;
	logic       halt;
	logic       invalid;
	logic [2:0] max_wait;
	int         cycles;
	rv_word_t   prog [$];
	rv_word_t   expect_q [$];

	rv_core_top u_dut (
		.clk (clk), .rst (rst),
		.wb_adr_o (wb_adr), .wb_dat_o (wb_dat_w), .wb_dat_i (wb_dat_r),
		.wb_sel_o (wb_sel), .wb_we_o (wb_we), .wb_cyc_o (wb_cyc),
		.wb_stb_o (wb_stb), .wb_ack_i (wb_ack),
		.pc_o (pc), .halt_o (halt), .invalid_o (invalid)
	);

	tb_wb_mem u_mem (
		.clk_i (clk), .adr_i (wb_adr), .dat_i (wb_dat_w), .dat_o (wb_dat_r),
		.sel_i (wb_sel), .we_i (wb_we), .cyc_i (wb_cyc), .stb_i (wb_stb),
		.ack_o (wb_ack), .max_wait_i (max_wait)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// global budget for the whole run
	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout: the core did not stop within %0d cycles", LIMIT);
			$display("SIMULATION FAILED");
			$fatal(1, "run aborted");
		end
	end

	task automatic check_word(input string name, input rv_word_t got, input rv_word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "flag mismatch");
		end
	endtask

	task automatic check_pc(input rv_word_t exp);
		if (pc !== exp) begin
			$display("[ERROR] pc_o got 0x%h expected 0x%h", pc, exp);
			$display("SIMULATION FAILED");
			$fatal(1, "pc mismatch");
		end
	endtask

	// instruction assembly through the union views
	function automatic rv_inst_u r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		rv_inst_u w;
		w.r = '{f7, rs2, rs1, f3, rd, `RV_OP_OP};
		return w;
	endfunction

	function automatic rv_inst_u i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		rv_inst_u w;
		w.i = '{imm, rs1, f3, rd, op};
		return w;
	endfunction

	function automatic rv_inst_u s_type(logic [11:0] imm, logic [4:0] rs2, logic [2:0] f3);
		rv_inst_u w;
		// base register is always x10
		w.s = '{imm[11:5], rs2, 5'd10, f3, imm[4:0], `RV_OP_STORE};
		return w;
	endfunction

	function automatic rv_inst_u b_type(rv_word_t off, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3);
		rv_inst_u w;
		w.s = '{{off[12], off[10:5]}, rs2, rs1, f3, {off[4:1], off[11]}, `RV_OP_BRANCH};
		return w;
	endfunction

	function automatic rv_inst_u u_type(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
		rv_inst_u w;
		w.u = '{imm, rd, op};
		return w;
	endfunction

	function automatic rv_inst_u j_type(rv_word_t off, logic [4:0] rd);
		rv_inst_u w;
		w.u = '{{off[20], off[10:1], off[11], off[19:12]}, rd, `RV_OP_JAL};
		return w;
	endfunction

	function automatic rv_word_t here();
		return 32'(prog.size() * 4);
	endfunction

	task automatic emit(input rv_inst_u w);
		prog.push_back(w);
	endtask

	// new program, x10 points at the data area
	task automatic begin_program();
		prog.delete();
		expect_q.delete();
		emit(u_type(20'h00001, 10, `RV_OP_LUI));
	endtask

	// words past the program hold a pattern of their own address
	task automatic load_program();
		for (int k = 0; k < u_mem.WORDS; k++)
			u_mem.mem[k] = (k < prog.size()) ? prog[k] : 32'hDEAD_0000 ^ rv_word_t'(4 * k);
	endtask

	// reset held four cycles, status quiet the whole time
	task automatic reset_core(input logic [2:0] waits);
		@(negedge clk);
		rst = 1'b0;
		max_wait = waits;
		repeat (4) begin
			@(negedge clk);
			check_flag("wb_cyc_o", wb_cyc, 1'b0);
			check_flag("wb_stb_o", wb_stb, 1'b0);
			check_flag("halt_o", halt, 1'b0);
			check_flag("invalid_o", invalid, 1'b0);
			check_pc(`RV_RESET_VEC);
		end
		rst = 1'b1;
	endtask

	task automatic wait_for_stop();
		while (!(halt || invalid))
			@(negedge clk);
	endtask

	task automatic run_program(input logic [2:0] waits);
		load_program();
		reset_core(waits);
		wait_for_stop();
		check_flag("halt_o", halt, 1'b1);
		check_flag("invalid_o", invalid, 1'b0);
	endtask

	task automatic check_results(input string what);
		foreach (expect_q[k])
			check_word($sformatf("%s mem[0x%h]", what, 32'h1000 + 4 * k),
				u_mem.mem[DATA + k], expect_q[k]);
	endtask

	// one alu instruction into x5, then its store
	task automatic alu_step(input rv_inst_u w, input rv_word_t exp);
		emit(w);
		emit(s_type(12'(4 * expect_q.size()), 5, `RV_F3_SW));
		expect_q.push_back(exp);
	endtask

	task automatic build_alu_program();
		rv_word_t x1;
		rv_word_t x2;
		x1 = 32'h1234_5678;
		x2 = 32'hFFFF_FED4;
		begin_program();
		emit(u_type(20'h12345, 1, `RV_OP_LUI));
		emit(i_type(12'h678, 1, `RV_F3_ADD, 1, `RV_OP_OPIMM));
		emit(i_type(12'hED4, 0, `RV_F3_ADD, 2, `RV_OP_OPIMM));
		emit(i_type(12'd13, 0, `RV_F3_ADD, 3, `RV_OP_OPIMM));
		alu_step(u_type(20'hABCDE, 5, `RV_OP_LUI), 32'hABCD_E000);
		alu_step(u_type(20'h00001, 5, `RV_OP_AUIPC), here() + 32'h1000);
		alu_step(i_type(12'hFFF, 1, `RV_F3_ADD, 5, `RV_OP_OPIMM), x1 - 1);
		alu_step(i_type(12'hED5, 2, `RV_F3_SLT, 5, `RV_OP_OPIMM),
			32'($signed(x2) < $signed(32'hFFFF_FED5)));
		alu_step(i_type(12'd5, 2, `RV_F3_SLTU, 5, `RV_OP_OPIMM), 32'(x2 < 32'd5));
		alu_step(i_type(12'h0F0, 1, `RV_F3_XOR, 5, `RV_OP_OPIMM), x1 ^ 32'h0F0);
		alu_step(i_type(12'h00F, 2, `RV_F3_OR, 5, `RV_OP_OPIMM), x2 | 32'h00F);
		alu_step(i_type(12'hFF0, 1, `RV_F3_AND, 5, `RV_OP_OPIMM), x1 & 32'hFFFF_FFF0);
		alu_step(i_type(12'h007, 1, `RV_F3_SLL, 5, `RV_OP_OPIMM), x1 << 7);
		alu_step(i_type(12'h009, 2, `RV_F3_SR, 5, `RV_OP_OPIMM), x2 >> 9);
		alu_step(i_type(12'h409, 2, `RV_F3_SR, 5, `RV_OP_OPIMM),
			rv_word_t'($signed(x2) >>> 9));
		alu_step(r_type(`RV_F7_BASE, 2, 1, `RV_F3_ADD, 5), x1 + x2);
		alu_step(r_type(`RV_F7_ALT, 2, 1, `RV_F3_ADD, 5), x1 - x2);
		alu_step(r_type(`RV_F7_BASE, 3, 1, `RV_F3_SLL, 5), x1 << 13);
		alu_step(r_type(`RV_F7_BASE, 1, 2, `RV_F3_SLT, 5), 32'($signed(x2) < $signed(x1)));
		alu_step(r_type(`RV_F7_BASE, 1, 2, `RV_F3_SLTU, 5), 32'(x2 < x1));
		alu_step(r_type(`RV_F7_BASE, 2, 1, `RV_F3_XOR, 5), x1 ^ x2);
		alu_step(r_type(`RV_F7_BASE, 3, 2, `RV_F3_SR, 5), x2 >> 13);
		alu_step(r_type(`RV_F7_ALT, 3, 2, `RV_F3_SR, 5), rv_word_t'($signed(x2) >>> 13));
		alu_step(r_type(`RV_F7_BASE, 2, 1, `RV_F3_OR, 5), x1 | x2);
		alu_step(r_type(`RV_F7_BASE, 2, 1, `RV_F3_AND, 5), x1 & x2);
		emit(`RV_INST_EBREAK);
	endtask

	task automatic test_reset_fetch();
		begin_program();
		emit(`RV_INST_EBREAK);
		load_program();
		reset_core(3'd0);
		while (!wb_cyc)
			@(negedge clk);
		check_word("wb_adr_o", wb_adr, `RV_RESET_VEC);
		check_flag("wb_we_o", wb_we, 1'b0);
		wait_for_stop();
		check_flag("halt_o", halt, 1'b1);
		check_pc(32'h0000_0004);
	endtask

	task automatic test_control_flow();
		rv_word_t loop_pc;
		rv_word_t link_pc;
		rv_word_t base_pc;
		begin_program();
		emit(i_type(12'd0, 0, `RV_F3_ADD, 1, `RV_OP_OPIMM));
		emit(i_type(12'd5, 0, `RV_F3_ADD, 2, `RV_OP_OPIMM));
		loop_pc = here();
		emit(i_type(12'd1, 1, `RV_F3_ADD, 1, `RV_OP_OPIMM));
		emit(b_type(loop_pc - here(), 2, 1, `RV_F3_BNE));
		emit(s_type(12'd0, 1, `RV_F3_SW));
		emit(i_type(12'd3, 0, `RV_F3_ADD, 4, `RV_OP_OPIMM));
		loop_pc = here();
		emit(i_type(12'd1, 3, `RV_F3_ADD, 3, `RV_OP_OPIMM));
		emit(b_type(loop_pc - here(), 4, 3, `RV_F3_BLT));
		emit(s_type(12'd4, 3, `RV_F3_SW));
		// forward beq and jal each skip one write to x6
		emit(b_type(32'd8, 0, 0, `RV_F3_BEQ));
		emit(i_type(12'd99, 0, `RV_F3_ADD, 6, `RV_OP_OPIMM));
		emit(s_type(12'd8, 6, `RV_F3_SW));
		link_pc = here() + 4;
		emit(j_type(32'd8, 7));
		emit(i_type(12'd77, 0, `RV_F3_ADD, 6, `RV_OP_OPIMM));
		emit(s_type(12'd12, 7, `RV_F3_SW));
		// odd computed target, jalr clears bit 0
		base_pc = here();
		emit(u_type(20'h0, 8, `RV_OP_AUIPC));
		emit(i_type(12'd17, 8, `RV_F3_ADD, 8, `RV_OP_OPIMM));
		emit(i_type(12'd0, 8, `RV_F3_JALR, 9, `RV_OP_JALR));
		emit(i_type(12'd55, 0, `RV_F3_ADD, 6, `RV_OP_OPIMM));
		emit(s_type(12'd16, 9, `RV_F3_SW));
		emit(s_type(12'd20, 6, `RV_F3_SW));
		emit(`RV_INST_EBREAK);
		expect_q = '{32'd5, 32'd3, 32'd0, link_pc, base_pc + 12, 32'd0};
		run_program(3'd0);
		check_results("flow");
	endtask

	task automatic test_byte_half();
		begin_program();
		emit(i_type(12'hF81, 0, `RV_F3_ADD, 1, `RV_OP_OPIMM));
		emit(u_type(20'h0000A, 2, `RV_OP_LUI));
		emit(i_type(12'hA5C, 2, `RV_F3_ADD, 2, `RV_OP_OPIMM));
		for (int k = 0; k < 4; k++) begin
			emit(s_type(12'(k), 1, `RV_F3_SB));
			emit(i_type(12'd1, 1, `RV_F3_ADD, 1, `RV_OP_OPIMM));
		end
		emit(s_type(12'd4, 2, `RV_F3_SH));
		emit(s_type(12'd10, 2, `RV_F3_SH));
		emit(i_type(12'd1, 10, `RV_F3_LB, 5, `RV_OP_LOAD));
		emit(i_type(12'd3, 10, `RV_F3_LBU, 6, `RV_OP_LOAD));
		emit(i_type(12'd10, 10, `RV_F3_LH, 7, `RV_OP_LOAD));
		emit(i_type(12'd4, 10, `RV_F3_LHU, 8, `RV_OP_LOAD));
		emit(i_type(12'd2, 10, `RV_F3_LB, 11, `RV_OP_LOAD));
		emit(i_type(12'd8, 10, `RV_F3_LHU, 12, `RV_OP_LOAD));
		emit(i_type(12'd0, 10, `RV_F3_LW, 13, `RV_OP_LOAD));
		// x0 written by alu and by load, then stored
		emit(i_type(12'd5, 0, `RV_F3_ADD, 0, `RV_OP_OPIMM));
		emit(i_type(12'd0, 10, `RV_F3_LW, 0, `RV_OP_LOAD));
		emit(s_type(12'd12, 0, `RV_F3_SW));
		emit(s_type(12'd16, 5, `RV_F3_SW));
		emit(s_type(12'd20, 6, `RV_F3_SW));
		emit(s_type(12'd24, 7, `RV_F3_SW));
		emit(s_type(12'd28, 8, `RV_F3_SW));
		emit(s_type(12'd32, 11, `RV_F3_SW));
		emit(s_type(12'd36, 12, `RV_F3_SW));
		emit(s_type(12'd40, 13, `RV_F3_SW));
		emit(`RV_INST_EBREAK);
		load_program();
		u_mem.mem[DATA + 1] = 32'h1111_1111;
		u_mem.mem[DATA + 2] = 32'h2222_2222;
		u_mem.mem[DATA + 3] = 32'h3333_3333;
		expect_q = '{32'h8483_8281, 32'h1111_9A5C, 32'h9A5C_2222, 32'h0,
			32'hFFFF_FF82, 32'h0000_0084, 32'hFFFF_9A5C, 32'h0000_9A5C,
			32'hFFFF_FF83, 32'h0000_2222, 32'h8483_8281};
		reset_core(3'd0);
		wait_for_stop();
		check_flag("halt_o", halt, 1'b1);
		check_results("bytes");
	endtask

	task automatic test_stops();
		// ebreak at 0x8, behind the base setup and one nop
		begin_program();
		emit(i_type(12'd0, 0, `RV_F3_ADD, 0, `RV_OP_OPIMM));
		emit(`RV_INST_EBREAK);
		run_program(3'd0);
		check_pc(32'h0000_0008);
		// illegal word at 0x8
		begin_program();
		emit(i_type(12'd0, 0, `RV_F3_ADD, 0, `RV_OP_OPIMM));
		emit(32'hFFFF_FFFF);
		load_program();
		reset_core(3'd0);
		wait_for_stop();
		check_flag("invalid_o", invalid, 1'b1);
		check_flag("halt_o", halt, 1'b0);
		check_pc(32'h0000_0008);
		repeat (16) begin
			@(negedge clk);
			check_flag("wb_cyc_o", wb_cyc, 1'b0);
		end
	endtask

	initial begin
		rst      = 1'b0;
		max_wait = 3'd0;
		cycles   = 0;
		test_reset_fetch();
		build_alu_program();
		run_program(3'd0);
		check_results("alu");
		test_control_flow();
		test_byte_half();
		// same alu program under random back-pressure
		build_alu_program();
		run_program(3'd7);
		check_results("alu waits");
		test_stops();
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_wb_mem.sv
`default_nettype none

module tb_wb_mem import rv_pkg::*; (
	input  logic       clk_i,
	input  rv_word_t   adr_i,
	input  rv_word_t   dat_i,
	output rv_word_t   dat_o,
	input  logic [3:0] sel_i,
	input  logic       we_i,
	input  logic       cyc_i,
	input  logic       stb_i,
	output logic       ack_o,
	input  logic [2:0] max_wait_i
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WORDS = 2048;

	rv_word_t    mem [WORDS];
	int          seed;
	int          wait_left;
	logic        busy;
	logic [10:0] idx;

	// word index, 8 KiB of memory
	assign idx = adr_i[12:2];

	initial begin
		seed      = 72;
		wait_left = 0;
		busy      = 1'b0;
		ack_o     = 1'b0;
		dat_o     = '0;
	end

	// responses change on the falling edge, core samples on the rising one
	always @(negedge clk_i) begin
		if (ack_o || !(cyc_i && stb_i)) begin
			ack_o <= 1'b0;
			busy = 1'b0;
		end else begin
			// new request, draw its wait states
			if (!busy) begin
				busy = 1'b1;
				if (max_wait_i == 3'd0)
					wait_left = 0;
				else
					wait_left = int'($unsigned($random(seed)) % (32'(max_wait_i) + 1));
			end
			if (wait_left == 0) begin
				ack_o <= 1'b1;
				busy = 1'b0;
				if (we_i) begin
					for (int b = 0; b < 4; b++) begin
						if (sel_i[b])
							mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
					end
				end else begin
					dat_o <= mem[idx];
				end
			end else begin
				wait_left--;
			end
		end
	end

endmodule

`default_nettype wire
